// ==== rtl/cpuFetchPkg.sv ====
package cpuFetchPkg;

	typedef logic [31:0] wordT; // one data or instruction word
	typedef logic [31:0] addrT; // byte address, as held in the PC and driven on the bus
	typedef logic [4:0] regNumT; // index into the 32 entry register file

	// first fetch address after reset
	localparam addrT resetVector = 32'h4;

	// major opcodes, found in bits 31:26 of the word
	localparam logic [5:0] opSpecial = 6'd0; // register jumps, selected by funct
	localparam logic [5:0] opRegimm = 6'd1; // sign tests on rs, selected by the rt field
	localparam logic [5:0] opJ = 6'd2;
	localparam logic [5:0] opJal = 6'd3;
	localparam logic [5:0] opBeq = 6'd4;
	localparam logic [5:0] opBne = 6'd5;
	localparam logic [5:0] opBlez = 6'd6;
	localparam logic [5:0] opBgtz = 6'd7;

	// funct codes under opSpecial, bits 5:0
	localparam logic [5:0] fnJr = 6'd8;
	localparam logic [5:0] fnJalr = 6'd9;

	// rt field codes under opRegimm, bits 20:16
	localparam regNumT rtBltz = 5'd0;
	localparam regNumT rtBgez = 5'd1;
	localparam regNumT rtBltzal = 5'd16; // bit 4 of the rt field marks the linking forms
	localparam regNumT rtBgezal = 5'd17;

	localparam regNumT linkReg = 5'd31; // return address register for JAL and REGIMM links

	// control-flow class of a fetched word; the linking forms share the class of their
	// plain partner and raise a separate link flag
	typedef enum logic [3:0] {
		cfNone, // anything that just falls through to the next word
		cfJ, // J and JAL, region jump
		cfJr, // JR and JALR, jump through rs
		cfBeq,
		cfBne,
		cfBgez, // also BGEZAL
		cfBgtz,
		cfBlez,
		cfBltz // also BLTZAL
	} cfClassT;

endpackage

// ==== rtl/fetchReqIf.sv ====
`timescale 1ns/1ps

interface fetchReqIf (
	input logic clk
);
	import cpuFetchPkg::*;

	logic req; // raised by the PC unit with addr and held until done
	addrT addr; // byte address of the wanted instruction
	wordT instr; // returned word, valid while done is high
	logic done; // single cycle pulse that closes the request

	modport pc (
		input clk,
		output req,
		output addr,
		input instr,
		input done
	);

	modport bus (
		input clk,
		input req,
		input addr,
		output instr,
		output done
	);

	// done only answers an open request, and the PC unit drops req before it can repeat
	donePulse: assert property (@(posedge clk) done |-> req ##1 !done);
endinterface

// ==== rtl/controlDecode.sv ====
`timescale 1ns/1ps

module controlDecode (
	input cpuFetchPkg::wordT instr,
	output cpuFetchPkg::cfClassT cfClass,
	output logic link,
	output cpuFetchPkg::regNumT rs,
	output cpuFetchPkg::regNumT rt,
	output cpuFetchPkg::regNumT linkNum,
	output logic [25:0] jumpIndex,
	output cpuFetchPkg::addrT branchOffset
);
	import cpuFetchPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	regNumT rd;

	// fixed field positions of the MIPS word formats
	assign opcode = instr[31:26];
	assign funct = instr[5:0]; // only looked at under opSpecial
	assign rd = instr[15:11]; // JALR link destination
	assign rs = instr[25:21];
	assign rt = instr[20:16]; // doubles as the REGIMM selector

	assign jumpIndex = instr[25:0]; // J format index, the PC unit adds the region bits

	// the 16 bit immediate counts words, so sign-extend it and turn it into bytes
	assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};

	always_comb begin
		cfClass = cfNone; // every word that is not control flow runs straight on
		link = 1'b0;
		linkNum = linkReg; // only JALR names its own destination
		case (opcode)
			opSpecial: begin
				if (funct == fnJr) begin
					cfClass = cfJr;
				end else if (funct == fnJalr) begin
					cfClass = cfJr;
					link = 1'b1;
					linkNum = rd; // return address goes where the word says
				end
			end
			opRegimm: begin
				case (rt)
					rtBltz: cfClass = cfBltz;
					rtBgez: cfClass = cfBgez;
					rtBltzal: begin
						cfClass = cfBltz;
						link = 1'b1; // links even when the branch falls through
					end
					rtBgezal: begin
						cfClass = cfBgez;
						link = 1'b1;
					end
					default: cfClass = cfNone; // other REGIMM codes are out of scope
				endcase
			end
			opJ: cfClass = cfJ;
			opJal: begin
				cfClass = cfJ;
				link = 1'b1;
			end
			opBeq: cfClass = cfBeq;
			opBne: cfClass = cfBne;
			opBlez: cfClass = cfBlez;
			opBgtz: cfClass = cfBgtz;
			default: cfClass = cfNone;
		endcase
	end

	// an unknown class would let X into the next-PC mux and from there onto wbAdr
	classKnown: assert final (!$isunknown(cfClass));

endmodule

// ==== rtl/gprFile.sv ====
`timescale 1ns/1ps

module gprFile (
	input logic clk,
	input logic reset,
	input cpuFetchPkg::regNumT raNum,
	input cpuFetchPkg::regNumT rbNum,
	output cpuFetchPkg::wordT raData,
	output cpuFetchPkg::wordT rbData,
	input logic linkWe,
	input cpuFetchPkg::regNumT linkNum,
	input cpuFetchPkg::wordT linkData,
	input logic regWe,
	input cpuFetchPkg::regNumT regNum,
	input cpuFetchPkg::wordT regData
);
	import cpuFetchPkg::*;

	wordT regs [32];
	logic wrEn;
	regNumT wrNum;
	wordT wrData;

	// reads are asynchronous so the PC unit can compare operands on the done cycle
	assign raData = (raNum == 5'd0) ? '0 : regs[raNum]; // r0 is hardwired to zero
	assign rbData = (rbNum == 5'd0) ? '0 : regs[rbNum];

	// one write port, the link from the PC unit wins over the outside writeback
	always_comb begin
		wrEn = 1'b0;
		wrNum = regNum;
		wrData = regData;
		if (linkWe) begin
			wrEn = 1'b1;
			wrNum = linkNum;
			wrData = linkData;
		end else if (regWe) begin
			wrEn = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrNum != 5'd0) begin // writes to r0 are dropped
			regs[wrNum] <= wrData;
		end
	end

endmodule

// ==== rtl/programCounter.sv ====
`timescale 1ns/1ps

module programCounter (
	input logic clk,
	input logic reset,
	input logic run,
	fetchReqIf.pc fetch,
	input cpuFetchPkg::wordT rsData,
	input cpuFetchPkg::wordT rtData,
	input cpuFetchPkg::cfClassT cfClass,
	input logic link,
	input cpuFetchPkg::regNumT linkNum,
	input logic [25:0] jumpIndex,
	input cpuFetchPkg::addrT branchOffset,
	output logic linkWe,
	output cpuFetchPkg::regNumT linkWrNum,
	output cpuFetchPkg::wordT linkData
);
	import cpuFetchPkg::*;

	addrT pc; // address of the word in flight, or of the next one to fetch
	addrT pendTarget; // redirect waiting for the delay-slot word to go by
	logic pending; // set while the word being fetched is a delay slot
	logic req;
	addrT slotAddr;
	addrT target;
	logic taken;

	assign fetch.req = req;
	assign fetch.addr = pc; // pc only moves on done, so addr is steady under req

	assign slotAddr = pc + 32'd4; // delay-slot address, also the base for branches
	assign linkData = pc + 32'd8; // return skips the delay slot

	// a word in a delay slot is plain sequential, so it neither redirects nor links
	assign linkWe = fetch.done && link && !pending;
	assign linkWrNum = linkNum;

	always_comb begin
		case (cfClass)
			cfJ: target = {slotAddr[31:28], jumpIndex, 2'b00}; // stays inside the 256MB region
			cfJr: target = rsData;
			default: target = slotAddr + branchOffset; // offset is already signed and in bytes
		endcase
	end

	// all the sign tests treat rs as two's complement
	always_comb begin
		case (cfClass)
			cfJ, cfJr: taken = 1'b1;
			cfBeq: taken = (rsData == rtData);
			cfBne: taken = (rsData != rtData);
			cfBgez: taken = ($signed(rsData) >= 32'sd0);
			cfBgtz: taken = ($signed(rsData) > 32'sd0);
			cfBlez: taken = ($signed(rsData) <= 32'sd0);
			cfBltz: taken = rsData[31]; // negative is just the sign bit
			default: taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetVector;
			pending <= 1'b0;
			req <= 1'b0;
		end else if (fetch.done) begin
			req <= 1'b0; // idle for one cycle while the new pc settles
			if (pending) begin
				pc <= pendTarget; // delay slot done, now take the redirect
				pending <= 1'b0;
			end else begin
				pc <= slotAddr; // the word after is always fetched next
				pending <= taken;
			end
		end else if (!req && run) begin
			req <= 1'b1; // run only gates new requests, an open one runs to done
		end
	end

	// target only matters for the fetch after the delay slot
	always_ff @(posedge clk) begin
		if (fetch.done && !pending && taken) begin
			pendTarget <= target;
		end
	end

	// a JR through a bad register value would put a misaligned address on the bus
	addrAligned: assert property (@(posedge clk) disable iff (reset)
		req |-> pc[1:0] == 2'b00);

	// the bus master relies on req and addr staying put for the whole read
	reqHeld: assert property (@(posedge clk) disable iff (reset)
		req && !fetch.done |=> req && $stable(pc));

endmodule

// ==== rtl/wbFetchMaster.sv ====
`timescale 1ns/1ps

module wbFetchMaster (
	input logic clk,
	input logic reset,
	fetchReqIf.bus fetch,
	output logic wbCyc,
	output logic wbStb,
	output cpuFetchPkg::addrT wbAdr,
	input cpuFetchPkg::wordT wbDatIn,
	input logic wbAck
);
	typedef enum logic {
		busIdle, // nothing on the bus
		busWait // cycle open, waiting for the slave to ack
	} busStateT;

	busStateT state;
	logic done;
	logic start;

	assign fetch.done = done;

	// req is still high while done is, so that cycle must not open a second read
	assign start = (state == busIdle) && fetch.req && !done;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= busIdle;
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0; // single cycle pulse
			case (state)
				busIdle: if (start) begin
					state <= busWait;
					wbCyc <= 1'b1;
					wbStb <= 1'b1;
				end
				busWait: if (wbAck) begin // slave wait states just hold us here
					state <= busIdle;
					wbCyc <= 1'b0;
					wbStb <= 1'b0;
					done <= 1'b1;
				end
				default: state <= busIdle;
			endcase
		end
	end

	// address and read data are plain payload registers
	always_ff @(posedge clk) begin
		if (start) wbAdr <= fetch.addr;
		if (state == busWait && wbAck) fetch.instr <= wbDatIn; // word held for decode on done
	end

	stbUnderCyc: assert property (@(posedge clk) disable iff (reset) $rose(wbStb) |-> wbCyc);

endmodule

// ==== rtl/fetchUnitTop.sv ====
`timescale 1ns/1ps

module fetchUnitTop (
	input logic clk,
	input logic reset,
	input logic run,
	input logic regWe,
	input cpuFetchPkg::regNumT regNum,
	input cpuFetchPkg::wordT regData,
	output logic wbCyc,
	output logic wbStb,
	output cpuFetchPkg::addrT wbAdr,
	input cpuFetchPkg::wordT wbDatIn,
	input logic wbAck
);
	import cpuFetchPkg::*;

	cfClassT cfClass;
	logic link;
	regNumT rsNum;
	regNumT rtNum;
	regNumT linkNum; // decoder's choice of link destination
	logic [25:0] jumpIndex;
	addrT branchOffset;
	wordT rsData;
	wordT rtData;
	logic linkWe;
	regNumT linkWrNum;
	wordT linkData;

	fetchReqIf fetchBus (.clk(clk)); // request and returned word between PC unit and bus

	controlDecode decode (
		.instr(fetchBus.instr), .cfClass(cfClass), .link(link),
		.rs(rsNum), .rt(rtNum), .linkNum(linkNum),
		.jumpIndex(jumpIndex), .branchOffset(branchOffset)
	);

	gprFile regFile (
		.clk(clk), .reset(reset),
		.raNum(rsNum), .rbNum(rtNum), .raData(rsData), .rbData(rtData),
		.linkWe(linkWe), .linkNum(linkWrNum), .linkData(linkData),
		.regWe(regWe), .regNum(regNum), .regData(regData) // outside loads while run is low
	);

	programCounter pcUnit (
		.clk(clk), .reset(reset), .run(run), .fetch(fetchBus.pc),
		.rsData(rsData), .rtData(rtData),
		.cfClass(cfClass), .link(link), .linkNum(linkNum),
		.jumpIndex(jumpIndex), .branchOffset(branchOffset),
		.linkWe(linkWe), .linkWrNum(linkWrNum), .linkData(linkData)
	);

	wbFetchMaster busMaster (
		.clk(clk), .reset(reset), .fetch(fetchBus.bus),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
		.wbDatIn(wbDatIn), .wbAck(wbAck)
	);

endmodule

// ==== tb/fetchUnitTb.sv ====
`timescale 1ns/1ps

module fetchUnitTb;
	import cpuFetchPkg::*;

	localparam int memWords = 1024; // 4 KB of program space, covers every address in the trace

	logic clk;
	logic reset;
	logic run;
	logic regWe;
	regNumT regNum;
	wordT regData;
	logic wbCyc;
	logic wbStb;
	addrT wbAdr;
	wordT wbDatIn;
	logic wbAck;

	wordT mem [memWords]; // Wishbone slave memory, word indexed
	regNumT loadNum [$]; // register preloads in trace order
	wordT loadData [$];
	int runLen [$]; // fetch count of each run block
	addrT expAddr [$]; // expected bus read addresses, consumed front first
	int cycleCount = 0;
	int cycleLimit = 100;
	logic [31:0] rngState;

	fetchUnitTop UUT (
		.clk(clk), .reset(reset), .run(run),
		.regWe(regWe), .regNum(regNum), .regData(regData),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
		.wbDatIn(wbDatIn), .wbAck(wbAck)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// prints the reason, then the fail line, then stops the simulation
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "run aborted");
	endtask

	// one fetch costs about five cycles plus the wait states, so the limit covers the worst case
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			abortRun($sformatf("fetch unit stalled, no progress after %0d cycles", cycleCount));
		end
	end

	task automatic checkAddr(input string name, input addrT got, input addrT want);
		if (got !== want) begin
			abortRun($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, want));
		end
	endtask

	task automatic checkBus(input string name, input logic got, input logic want);
		if (got !== want) begin
			abortRun($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, got, want));
		end
	endtask

	// 32 bit xorshift, gives the ack wait states
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// records are a key letter and its fields, several may share a line and # starts a comment
	task automatic readTrace();
		int fd;
		int n;
		logic [7:0] kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [8*160-1:0] rest;
		fd = $fopen("tb/branch_trace.txt", "r");
		if (fd == 0) begin
			abortRun("cannot open the trace file tb/branch_trace.txt");
		end
		// opcode 63 decodes as a plain word, and the low bits carry the word's own address
		for (int i = 0; i < memWords; i++) begin
			mem[i] = 32'hFC00_0000 | (i << 2);
		end
		while ($fscanf(fd, " %c", kind) == 1) begin
			case (kind)
				"#": n = $fgets(rest, fd); // skip the rest of the line
				"M": begin
					n = $fscanf(fd, "%h %h", a, b);
					if (n != 2 || a >= memWords * 4) abortRun("bad memory record in the trace");
					mem[a[11:2]] = b;
				end
				"R": begin
					n = $fscanf(fd, "%d %h", a, b);
					if (n != 2) abortRun("bad register record in the trace");
					loadNum.push_back(a[4:0]);
					loadData.push_back(b);
				end
				"G": begin
					n = $fscanf(fd, "%d", a);
					if (n != 1) abortRun("bad run record in the trace");
					runLen.push_back(a);
				end
				"E": begin
					n = $fscanf(fd, "%h", a);
					if (n != 1) abortRun("bad expected address record in the trace");
					expAddr.push_back(a);
				end
				default: abortRun($sformatf("unknown record key %c in the trace", kind));
			endcase
		end
		$fclose(fd);
	endtask

	// answers one classic read after 0 to 3 wait states, and drops run with the last ack
	task automatic serveRead(input logic lastOfRun);
		int waits;
		addrT want;
		@(posedge clk);
		while (!(wbCyc && wbStb)) @(posedge clk); // values here are from before the edge
		if (expAddr.size() == 0) begin
			abortRun("the DUT read more words than the trace expects");
		end
		want = expAddr.pop_front();
		checkAddr("wbAdr", wbAdr, want);
		rngState = xorshift32(rngState);
		waits = rngState % 4;
		repeat (waits) @(posedge clk);
		wbAck <= 1'b1;
		wbDatIn <= mem[wbAdr[11:2]];
		if (lastOfRun) run <= 1'b0; // a fetch already open still completes
		@(posedge clk);
		wbAck <= 1'b0; // ack was seen on this edge, cycle closes on it too
	endtask

	initial begin
		reset = 1'b1;
		run = 1'b0;
		regWe = 1'b0;
		regNum = '0;
		regData = '0;
		wbDatIn = '0;
		wbAck = 1'b0;
		rngState = 32'd26408;
		readTrace();
		for (int g = 0; g < runLen.size(); g++) begin
			cycleLimit = cycleLimit + runLen[g] * 7;
		end
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		// preloads go in with run low, the PC unit stays parked at resetVector meanwhile
		for (int i = 0; i < loadNum.size(); i++) begin
			@(posedge clk);
			regWe <= 1'b1;
			regNum <= loadNum[i];
			regData <= loadData[i];
		end
		@(posedge clk);
		regWe <= 1'b0;
		for (int g = 0; g < runLen.size(); g++) begin
			@(posedge clk);
			run <= 1'b1;
			for (int k = 0; k < runLen[g]; k++) begin
				serveRead(k == runLen[g] - 1);
			end
			// paused, so the bus has to stay quiet
			repeat (6) begin
				@(posedge clk);
				checkBus("wbCyc", wbCyc, 1'b0);
				checkBus("wbStb", wbStb, 1'b0);
			end
		end
		if (expAddr.size() != 0) begin
			abortRun($sformatf("%0d expected fetch addresses were never read", expAddr.size()));
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

// ==== tb/branch_trace.txt ====
# M byte address and word (hex) | R register (dec) and value (hex) | G fetches in one run
# E expected bus read address (hex), in order; words not listed are plain sequential
M 010 08000040 # J 0x100
M 104 0C000080 # JAL 0x200, links 0x10c
M 204 03E00008 # JR r31
M 10C 10220004 # BEQ r1 r2 taken forward to 0x120
M 120 10230008 # BEQ r1 r3 not taken
M 128 1423FFED # BNE r1 r3 taken backward to 0x0e0
M 0E0 14220010 # BNE r1 r2 not taken
M 0E8 080000C0 # J 0x300
M 300 04810002 # BGEZ r4 negative, falls through
M 30C 04010002 # BGEZ r0 zero, taken
M 318 04C10002 # BGEZ r6 positive, taken
M 324 1C800002 # BGTZ negative
M 330 1C000002 # BGTZ zero
M 33C 1CC00002 # BGTZ positive, taken
M 348 18800002 # BLEZ negative, taken
M 354 18000002 # BLEZ zero, taken
M 360 18C00002 # BLEZ positive
M 36C 04800002 # BLTZ negative, taken
M 378 04000002 # BLTZ zero
M 384 04C00002 # BLTZ positive
M 390 04910002 # BGEZAL r4 not taken, still links 0x398
M 398 08000140 # J 0x500
M 500 03E0F809 # JALR r31 r31, returns through the old link
M 508 04D00002 # BLTZAL r6 not taken, links 0x510
M 510 08000180 # J 0x600
M 600 03E0F809 # JALR r31 r31
M 608 080001C0 # J 0x700
M 60C 08000200 # J 0x800 in a delay slot, runs as a plain word
R 1 00000005
R 2 00000005
R 3 00000007
R 4 fffffffd
R 6 00000009
# straight line, J, JAL and JR return, BEQ and BNE; the run stops inside a delay slot
E 004 E 008 E 00c E 010 E 014 E 100 E 104 E 108
E 200 E 204 E 208 E 10c E 110 E 120 E 124 E 128
E 12c E 0e0 E 0e4 E 0e8 E 0ec
G 21
# sign tests on negative, zero and positive rs
E 300 E 304 E 308 E 30c E 310 E 318 E 31c E 324
E 328 E 32c E 330 E 334 E 338 E 33c E 340 E 348
E 34c E 354 E 358 E 360 E 364 E 368 E 36c E 370
E 378 E 37c E 380 E 384 E 388 E 38c
G 30
# links from untaken branches and JALR, then a jump in a delay slot
E 390 E 394 E 398 E 39c E 500 E 504 E 398 E 39c
E 500 E 504 E 508 E 50c E 510 E 514 E 600 E 604
E 510 E 514 E 600 E 604 E 608 E 60c E 700 E 704
G 24

// ==== sources.f ====
rtl/cpuFetchPkg.sv
rtl/fetchReqIf.sv
rtl/controlDecode.sv
rtl/gprFile.sv
rtl/programCounter.sv
rtl/wbFetchMaster.sv
rtl/fetchUnitTop.sv
tb/fetchUnitTb.sv
